// ==== project.f ====
+incdir+tb
verilog/serdes_rx_pkg.sv
verilog/serdes_rx_align.sv
verilog/serdes_rx_framer.sv
verilog/serdes_rx_crc16.sv
verilog/serdes_rx_fifo.sv
verilog/serdes_rx_link_mon.sv
verilog/serdes_rx_top.sv
tb/serdes_rx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the SERDES receive testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
   --top-module serdes_rx_tb \
   -Mdir obj_dir \
   -f project.f

./obj_dir/Vserdes_rx_tb | tee "$LOG"

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
   echo "Simulation reported failure, see $LOG"
   exit 1
fi

if ! grep -q '\*\*\* PASSED \*\*\*' "$LOG"; then
   echo "Simulation ended without a result line, see $LOG"
   exit 1
fi

echo "Simulation finished cleanly"

// ==== tb/serdes_rx_tb_tasks.svh ====
// ----------------------------------------------------------------------
// SERDES receive testbench helpers
// Transmitter byte-stream model, reference CRC and expected entries
// ----------------------------------------------------------------------

`ifndef SERDES_RX_TB_TASKS_SVH
`define SERDES_RX_TB_TASKS_SVH

logic [8:0]         tx_q[$];    // {K flag, byte} in line order
logic [ENTRY_W-1:0] exp_q[$];   // {error, start, end, line}
int                 xon_sent;
int                 xoff_sent;

// Bytewise CCITT, high byte of the halfword enters first
function automatic logic [15:0] crc16_ref(input logic [15:0] crc, input logic [15:0] half);
   logic [15:0] c;
   logic [7:0]  b;
   int          n;
   int          j;
   c = crc;
   for (n = 1; n >= 0; n--)
   begin
      b = half[n*8 +: 8];
      c = c ^ {b, 8'h00};
      for (j = 0; j < 8; j++)
         c = c[15] ? ((c << 1) ^ 16'h1021) : (c << 1);
   end
   return c;
endfunction

// Low byte goes out first
task automatic push_word(input logic [17:0] w);
   tx_q.push_back({w[16], w[7:0]});
   tx_q.push_back({w[17], w[15:8]});
endtask

// One packet with idles around it, room is the free FIFO space
task automatic queue_packet(input int lines, input bit odd_lane, input bit with_waits,
                            input bit bad_crc, input int room);
   logic [15:0] half;
   logic [15:0] lo_half;
   logic [15:0] crc;
   int          n;
   crc     = CRC_INIT;
   lo_half = 16'h0000;
   if (odd_lane)
      tx_q.push_back({1'b0, D_56});   // One byte shift onto the odd lane
   push_word(IDLE_WORD);
   push_word(IDLE_WORD);
   push_word(START_WORD);
   if (with_waits)
   begin
      push_word(XOFF_WORD);
      xoff_sent++;
   end
   for (n = 0; n < 2 * lines; n++)
   begin
      half = 16'($random(seed));
      crc  = crc16_ref(crc, half);
      push_word({2'b00, half});
      if (with_waits && (n % 9 == 1))
         push_word(IDLE_WORD);
      else if (with_waits && (n % 9 == 4))
      begin
         push_word(XON_WORD);   // Between the two halves of a line
         xon_sent++;
      end
      else if (with_waits && (n % 9 == 7))
      begin
         push_word(XOFF_WORD);
         xoff_sent++;
      end
      if (n % 2 == 0)
         lo_half = half;
      else if (n / 2 < room)
         exp_q.push_back({1'b0, (n == 1), 1'b0, half, lo_half});
   end
   push_word(END_WORD);
   if (with_waits)
   begin
      push_word(XON_WORD);
      xon_sent++;
   end
   push_word({2'b00, bad_crc ? ~crc : crc});
   repeat (4) push_word(IDLE_WORD);
   if (odd_lane)
      tx_q.push_back({1'b0, D_56});
   push_word(IDLE_WORD);
   // Overflow and bad CRC both end in one error entry
   if ((lines >= room) || bad_crc)
      exp_q.push_back({3'b111, 32'h0000_0000});
   else
      exp_q.push_back({3'b001, 16'h0000, crc});
endtask

// Two bytes per clock on the falling edge
task automatic send_queued();
   logic [8:0] lo;
   logic [8:0] hi;
   while (tx_q.size() >= 2)
   begin
      lo = tx_q.pop_front();
      hi = tx_q.pop_front();
      @(negedge ser_rx_clk);
      {ser_rx_kmsb_i, ser_rx_klsb_i, ser_rx_data_i} = {hi[8], lo[8], hi[7:0], lo[7:0]};
   end
endtask

`endif

// ==== tb/serdes_rx_tb.sv ====
// ----------------------------------------------------------------------
// SERDES receive testbench
// Packets on both lanes, wait words, bad CRC, overflow, link monitor
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module serdes_rx_tb
   import serdes_rx_pkg::*;
;

   localparam int TB_FIFO_AW  = 4;
   localparam int FIFO_DEPTH  = 1 << TB_FIFO_AW;
   localparam int CLK_PERIOD  = 8;
   localparam int NO_LIMIT    = 1000;
   localparam int DRAIN_LIMIT = 64;   // Cycles
   localparam int LINES_EVEN  = 6;
   localparam int LINES_ODD   = 7;
   localparam int LINES_WAIT  = 5;
   localparam int LINES_BAD   = 4;
   localparam int LINES_LONG  = FIFO_DEPTH + 4;
   localparam int LINES_AFTER = 3;
   localparam int LOS_WORDS   = 6;
   localparam int PKT_WORDS   = 12;   // Framing and idle words per packet
   localparam int WORD_BUDGET = 16 + LOS_WORDS + 1 + 6 * PKT_WORDS +
      3 * (LINES_EVEN + LINES_ODD + LINES_WAIT + LINES_BAD + LINES_LONG + LINES_AFTER);

   logic                ser_rx_clk = 1'b0;
   logic                rst_rxclk;
   logic [15:0]         ser_rx_data_i;
   logic                ser_rx_klsb_i;
   logic                ser_rx_kmsb_i;
   logic                out_ready_i;
   logic [31:0]         out_data_o;
   logic                out_sop_o;
   logic                out_eop_o;
   logic                out_err_o;
   logic                out_valid_o;
   logic [TB_FIFO_AW:0] fifo_space_o;
   logic [TB_FIFO_AW:0] fifo_occupied_o;
   logic                fifo_full_o;
   logic                fifo_empty_o;
   logic                link_up_o;
   logic                xon_o;
   logic                xoff_o;

   int seed = 4344;
   int errors = 0;
   int checks = 0;
   int tests = 0;
   int mon_errors = 0;
   int mon_checks = 0;
   int rd_idx = 0;        // Next expected entry
   int xon_seen = 0;
   int xoff_seen = 0;
   int base;
   int xon_base;
   int xoff_base;
   int rise;
   logic [ENTRY_W-1:0] exp_entry;

   `include "serdes_rx_tb_tasks.svh"

   serdes_rx_top #(
      .FIFO_AW (TB_FIFO_AW)
   ) UUT (
      .ser_rx_clk      (ser_rx_clk),
      .rst_rxclk       (rst_rxclk),
      .ser_rx_data_i   (ser_rx_data_i),
      .ser_rx_klsb_i   (ser_rx_klsb_i),
      .ser_rx_kmsb_i   (ser_rx_kmsb_i),
      .out_ready_i     (out_ready_i),
      .out_data_o      (out_data_o),
      .out_sop_o       (out_sop_o),
      .out_eop_o       (out_eop_o),
      .out_err_o       (out_err_o),
      .out_valid_o     (out_valid_o),
      .fifo_space_o    (fifo_space_o),
      .fifo_occupied_o (fifo_occupied_o),
      .fifo_full_o     (fifo_full_o),
      .fifo_empty_o    (fifo_empty_o),
      .link_up_o       (link_up_o),
      .xon_o           (xon_o),
      .xoff_o          (xoff_o)
   );

   always #(CLK_PERIOD / 2) ser_rx_clk = ~ser_rx_clk;

   function automatic bit field_ok(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
      assert (actual === expected)
      else
         $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      return (actual === expected);
   endfunction

   task automatic expect_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
      checks++;
      if (!field_ok(name, expected, actual))
         errors++;
   endtask

   // Waits until every expected entry has been read out
   task automatic wait_drained(input int limit);
      int t;
      t = 0;
      while ((rd_idx < exp_q.size()) && (t < limit))
      begin
         @(negedge ser_rx_clk);
         t++;
      end
      checks++;
      assert (rd_idx == exp_q.size())
      else
      begin
         errors++;
         $display("Output stream stalled, %0d expected entries missing at %0t ns",
                  exp_q.size() - rd_idx, $time);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      int errs;
      errs = errors + mon_errors - errs_before;
      tests++;
      if (errs == 0)
         $display("Test %0d %s: ok", tests, name);
      else
         $display("Test %0d %s: %0d errors", tests, name, errs);
   endtask

   // Output stream monitor samples before the edge updates
   always @(posedge ser_rx_clk)
   begin
      if (!rst_rxclk)
      begin
         if (xon_o)
            xon_seen++;
         if (xoff_o)
            xoff_seen++;
         if (out_valid_o && out_ready_i)
         begin
            mon_checks++;
            assert (rd_idx < exp_q.size())
            else
            begin
               mon_errors++;
               $display("Output entry %h arrived with none expected at %0t ns",
                        {out_err_o, out_sop_o, out_eop_o, out_data_o}, $time);
            end
            if (rd_idx < exp_q.size())
            begin
               exp_entry = exp_q[rd_idx];
               rd_idx++;
               if (!field_ok("out_data_o", exp_entry[31:0], out_data_o))
                  mon_errors++;
               if (!field_ok("out_eop_o", 32'(exp_entry[32]), 32'(out_eop_o)))
                  mon_errors++;
               if (!field_ok("out_sop_o", 32'(exp_entry[33]), 32'(out_sop_o)))
                  mon_errors++;
               if (!field_ok("out_err_o", 32'(exp_entry[34]), 32'(out_err_o)))
                  mon_errors++;
            end
         end
      end
   end

   initial
   begin
      #(20 * WORD_BUDGET * CLK_PERIOD);
      $display("Watchdog expired before the test sequence finished");
      $display("*** FAILED ***");
      $finish;
   end

   initial
   begin
      rst_rxclk   = 1'b1;
      out_ready_i = 1'b1;
      {ser_rx_kmsb_i, ser_rx_klsb_i, ser_rx_data_i} = IDLE_WORD;
      xon_sent  = 0;
      xoff_sent = 0;
      repeat (16) @(posedge ser_rx_clk);
      @(negedge ser_rx_clk);
      rst_rxclk = 1'b0;

      base = errors + mon_errors;
      expect_value("out_valid_o", 32'd0, 32'(out_valid_o));
      expect_value("xon_o", 32'd0, 32'(xon_o));
      expect_value("xoff_o", 32'd0, 32'(xoff_o));
      expect_value("link_up_o", 32'd0, 32'(link_up_o));
      expect_value("fifo_full_o", 32'd0, 32'(fifo_full_o));
      expect_value("fifo_empty_o", 32'd1, 32'(fifo_empty_o));
      expect_value("fifo_space_o", FIFO_DEPTH, 32'(fifo_space_o));
      expect_value("fifo_occupied_o", 32'd0, 32'(fifo_occupied_o));
      report_test("reset state", base);

      base = errors + mon_errors;
      queue_packet(LINES_EVEN, 1'b0, 1'b0, 1'b0, NO_LIMIT);
      queue_packet(LINES_ODD, 1'b1, 1'b0, 1'b0, NO_LIMIT);
      send_queued();
      wait_drained(DRAIN_LIMIT);
      report_test("packets on even and odd lane", base);

      base      = errors + mon_errors;
      xon_base  = xon_seen;
      xoff_base = xoff_seen;
      queue_packet(LINES_WAIT, 1'b0, 1'b1, 1'b0, NO_LIMIT);
      send_queued();
      wait_drained(DRAIN_LIMIT);
      expect_value("xon_o pulses", xon_sent, xon_seen - xon_base);
      expect_value("xoff_o pulses", xoff_sent, xoff_seen - xoff_base);
      report_test("wait words inside a packet", base);

      base = errors + mon_errors;
      queue_packet(LINES_BAD, 1'b0, 1'b0, 1'b1, NO_LIMIT);
      send_queued();
      wait_drained(DRAIN_LIMIT);
      report_test("bad CRC", base);

      // Reader stalled while a packet longer than the FIFO arrives
      base        = errors + mon_errors;
      out_ready_i = 1'b0;
      queue_packet(LINES_LONG, 1'b0, 1'b0, 1'b0, FIFO_DEPTH);
      send_queued();
      repeat (4) @(negedge ser_rx_clk);
      expect_value("fifo_full_o", 32'd1, 32'(fifo_full_o));
      expect_value("fifo_occupied_o", FIFO_DEPTH, 32'(fifo_occupied_o));
      expect_value("fifo_space_o", 32'd0, 32'(fifo_space_o));
      out_ready_i = 1'b1;
      wait_drained(DRAIN_LIMIT);
      queue_packet(LINES_AFTER, 1'b1, 1'b0, 1'b0, NO_LIMIT);
      send_queued();
      wait_drained(DRAIN_LIMIT);
      report_test("back-pressure and overflow", base);

      base = errors + mon_errors;
      expect_value("link_up_o", 32'd1, 32'(link_up_o));
      repeat (LOS_WORDS) push_word(LOS_WORD);
      send_queued();
      push_word(IDLE_WORD);
      send_queued();   // First good word now at the pins
      expect_value("link_up_o", 32'd0, 32'(link_up_o));
      rise = 0;
      while (!link_up_o && (rise < 8))
      begin
         @(negedge ser_rx_clk);
         rise++;
      end
      checks++;
      assert (rise <= 4)
      else
      begin
         errors++;
         $display("Link did not come back up within 4 cycles, took %0d", rise);
      end
      report_test("link monitor", base);

      $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks + mon_checks,
               errors + mon_errors);
      if (errors + mon_errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// ==== verilog/serdes_rx_align.sv ====
// ----------------------------------------------------------------------
// SERDES receive byte-lane aligner
// Builds the odd-lane word from the held high byte and selects a lane
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module serdes_rx_align
   import serdes_rx_pkg::*;
(
   input  logic        ser_rx_clk,
   input  logic        rst_rxclk,
   input  logic [15:0] rx_data_i,
   input  logic        rx_klsb_i,
   input  logic        rx_kmsb_i,
   input  logic        odd_sel_i,
   output logic [15:0] lane_word_o,
   output logic [1:0]  lane_k_o,
   output logic        start_even_o,
   output logic        start_odd_o
);

   logic [8:0]  held_q;     // {K flag, high byte} of last word
   logic [17:0] even_word;
   logic [17:0] odd_word;
   logic [17:0] sel_word;

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
         held_q <= 9'd0;
      else
         held_q <= {rx_kmsb_i, rx_data_i[15:8]};
   end

   assign even_word = {rx_kmsb_i, rx_klsb_i, rx_data_i};

   // Halfword straddling two words, the held byte went out first
   assign odd_word = {rx_klsb_i, held_q[8], rx_data_i[7:0], held_q[7:0]};

   assign sel_word = odd_sel_i ? odd_word : even_word;

   assign lane_k_o    = sel_word[17:16];
   assign lane_word_o = sel_word[15:0];

   // Start word seen on either lane, framer picks the lane
   assign start_even_o = (even_word == START_WORD);
   assign start_odd_o  = (odd_word == START_WORD);

endmodule

// ==== verilog/serdes_rx_crc16.sv ====
// ----------------------------------------------------------------------
// Running CCITT CRC-16, 16 data bits per clock, MSB first
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module serdes_rx_crc16
   import serdes_rx_pkg::*;
(
   input  logic        ser_rx_clk,
   input  logic        rst_rxclk,
   input  logic        clear_i,
   input  logic        en_i,
   input  logic [15:0] data_i,
   output logic [15:0] crc_o
);

   localparam logic [15:0] POLY = 16'h1021;

   logic [15:0] crc_q;
   logic [15:0] crc_next;

   // Bit-serial update unrolled over the halfword
   always_comb
   begin
      crc_next = crc_q;
      for (int i = 15; i >= 0; i--)
         crc_next = {crc_next[14:0], 1'b0} ^ ((crc_next[15] ^ data_i[i]) ? POLY : 16'h0000);
   end

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk || clear_i)
         crc_q <= CRC_INIT;
      else if (en_i)
         crc_q <= crc_next;
   end

   assign crc_o = crc_q;   // Value before the current word

endmodule

// ==== verilog/serdes_rx_fifo.sv ====
// ----------------------------------------------------------------------
// SERDES receive FIFO
// Synchronous first-word-fall-through buffer of framer entries
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module serdes_rx_fifo
   import serdes_rx_pkg::*;
#(
   parameter int FIFO_AW = 5
)
(
   input  logic               ser_rx_clk,
   input  logic               rst_rxclk,
   input  logic               wr_en_i,
   input  logic [ENTRY_W-1:0] wr_data_i,
   input  logic               rd_ready_i,
   output logic               has_space_o,
   output logic               rd_valid_o,
   output logic [ENTRY_W-1:0] rd_data_o,
   output logic [FIFO_AW:0]   space_o,
   output logic [FIFO_AW:0]   occupied_o,
   output logic               full_o,
   output logic               empty_o
);

   localparam logic [FIFO_AW:0] DEPTH = 1 << FIFO_AW;

   logic [ENTRY_W-1:0] mem [0:DEPTH-1];
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic [FIFO_AW:0]   count;
   logic               do_wr;
   logic               do_rd;

   assign full_o  = (count == DEPTH);
   assign empty_o = (count == '0);

   assign do_wr = wr_en_i && !full_o;      // Drop on overflow
   assign do_rd = rd_ready_i && !empty_o;

   always_ff @(posedge ser_rx_clk)
   begin
      if (do_wr)
         mem[wr_ptr] <= wr_data_i;
   end

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         if (do_wr && !do_rd)
            count <= count + 1'b1;
         else if (do_rd && !do_wr)
            count <= count - 1'b1;
      end
   end

   // Head entry shows straight from the array
   assign rd_data_o   = mem[rd_ptr];
   assign rd_valid_o  = !empty_o;
   assign has_space_o = !full_o;
   assign space_o     = DEPTH - count;
   assign occupied_o  = count;

endmodule

// ==== verilog/serdes_rx_framer.sv ====
// ----------------------------------------------------------------------
// SERDES receive framer
// Parses start, payload, end and CRC words into 32-bit FIFO entries
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module serdes_rx_framer
   import serdes_rx_pkg::*;
(
   input  logic               ser_rx_clk,
   input  logic               rst_rxclk,
   input  logic [15:0]        lane_word_i,
   input  logic [1:0]         lane_k_i,
   input  logic               start_even_i,
   input  logic               start_odd_i,
   input  logic [15:0]        crc_i,
   input  logic               has_space_i,
   output logic               odd_sel_o,
   output logic               crc_clear_o,
   output logic               crc_en_o,
   output logic               wr_en_o,
   output logic [ENTRY_W-1:0] wr_data_o
);

   framer_state_t      state;
   logic               odd_q;
   logic               sop_q;       // Start flag for the first line
   logic               wr_en_q;
   logic [ENTRY_W-1:0] wr_data_q;
   logic [15:0]        half_q;      // Low half of the line

   logic [17:0] lane;
   logic        is_data;
   logic        is_wait;
   logic        in_first_half;
   logic        in_second_half;
   logic        half_accept;
   logic        line_word;
   logic        line_accept;
   logic        crc_match;
   logic        err_write;

   assign lane    = {lane_k_i, lane_word_i};
   assign is_data = (lane_k_i == 2'b00);

   // Idle and flow-control words are skipped
   assign is_wait = (lane == IDLE_WORD) || (lane == XON_WORD) || (lane == XOFF_WORD);

   assign in_first_half  = (state == ST_FIRST1) || (state == ST_PKT1);
   assign in_second_half = (state == ST_FIRST2) || (state == ST_PKT2);

   assign half_accept = in_first_half && is_data;
   assign line_word   = in_second_half && is_data;
   assign line_accept = line_word && has_space_i;
   assign crc_match   = (state == ST_CRC) && (lane == {2'b00, crc_i});
   assign err_write   = (state == ST_ERROR) && has_space_i;

   // CRC covers payload halfwords only
   assign crc_clear_o = (state == ST_IDLE);
   assign crc_en_o    = half_accept || line_word;

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
      begin
         state   <= ST_IDLE;
         odd_q   <= 1'b0;
         sop_q   <= 1'b0;
         wr_en_q <= 1'b0;
      end
      else
      begin
         wr_en_q <= 1'b0;
         case (state)
            ST_IDLE:
            begin
               if (start_even_i)
               begin
                  odd_q <= 1'b0;
                  sop_q <= 1'b1;
                  state <= ST_FIRST1;
               end
               else if (start_odd_i)
               begin
                  odd_q <= 1'b1;
                  sop_q <= 1'b1;
                  state <= ST_FIRST1;
               end
            end
            ST_FIRST1, ST_PKT1:
            begin
               if (is_data)
                  state <= (state == ST_FIRST1) ? ST_FIRST2 : ST_PKT2;
               else if ((state == ST_PKT1) && (lane == END_WORD))
                  state <= ST_CRC;
               else if (!is_wait)
                  state <= ST_ERROR;
            end
            ST_FIRST2, ST_PKT2:
            begin
               if (line_accept)
               begin
                  wr_en_q <= 1'b1;
                  sop_q   <= 1'b0;
                  state   <= ST_PKT1;
               end
               else if (!is_wait)
                  state <= ST_ERROR;   // Bad word or FIFO full
            end
            ST_CRC:
            begin
               if (crc_match && has_space_i)
               begin
                  wr_en_q <= 1'b1;
                  state   <= ST_DONE;
               end
               else if (!is_wait)
                  state <= ST_ERROR;
            end
            ST_ERROR:
            begin
               if (err_write)
               begin
                  wr_en_q <= 1'b1;
                  state   <= ST_IDLE;
               end
            end
            default:
               state <= ST_IDLE;   // ST_DONE
         endcase
      end
   end

   always_ff @(posedge ser_rx_clk)
   begin
      if (half_accept)
         half_q <= lane_word_i;
      if (line_accept)
         wr_data_q <= {1'b0, sop_q, 1'b0, lane_word_i, half_q};
      else if (crc_match)
         wr_data_q <= {1'b0, sop_q, 1'b1, 16'h0000, lane_word_i};
      else if (err_write)
         wr_data_q <= {3'b111, 32'h0000_0000};
   end

   assign odd_sel_o = odd_q;
   assign wr_en_o   = wr_en_q;
   assign wr_data_o = wr_data_q;

endmodule

// ==== verilog/serdes_rx_link_mon.sv ====
// ----------------------------------------------------------------------
// SERDES link monitor
// Link-up filter and XON/XOFF token detection on the raw input
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module serdes_rx_link_mon
   import serdes_rx_pkg::*;
(
   input  logic        ser_rx_clk,
   input  logic        rst_rxclk,
   input  logic [15:0] rx_data_i,
   input  logic        rx_klsb_i,
   input  logic        rx_kmsb_i,
   output logic        link_up_o,
   output logic        xon_o,
   output logic        xoff_o
);

   logic [17:0] raw_word;
   logic        good;
   logic [3:0]  hist_q;   // Newest sample in bit 0
   logic        xon_q;
   logic        xoff_q;

   assign raw_word = {rx_kmsb_i, rx_klsb_i, rx_data_i};
   assign good     = (raw_word != ERR_WORD) && (raw_word != LOS_WORD);

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
      begin
         hist_q <= 4'd0;
         xon_q  <= 1'b0;
         xoff_q <= 1'b0;
      end
      else
      begin
         hist_q <= {hist_q[2:0], good};
         // Token on either byte counts
         xon_q  <= ({rx_kmsb_i, rx_data_i[15:8]} == {1'b1, K_XON}) ||
                   ({rx_klsb_i, rx_data_i[7:0]} == {1'b1, K_XON});
         xoff_q <= ({rx_kmsb_i, rx_data_i[15:8]} == {1'b1, K_XOFF}) ||
                   ({rx_klsb_i, rx_data_i[7:0]} == {1'b1, K_XOFF});
      end
   end

   assign link_up_o = &hist_q[3:1];   // Three older samples good
   assign xon_o     = xon_q;
   assign xoff_o    = xoff_q;

endmodule

// ==== verilog/serdes_rx_pkg.sv ====
// ----------------------------------------------------------------------
// SERDES receive package
// K-code bytes, 18-bit lane word constants and the framer state type
// ----------------------------------------------------------------------

package serdes_rx_pkg;

   // K codes, sent with the K flag set
   localparam logic [7:0] K_COMMA     = 8'hBC;  // K28.5
   localparam logic [7:0] K_IDLE      = 8'h3C;  // K28.1
   localparam logic [7:0] K_PKT_START = 8'hDC;  // K28.6
   localparam logic [7:0] K_PKT_END   = 8'h9C;  // K28.4
   localparam logic [7:0] K_XON       = 8'h5C;  // K28.2
   localparam logic [7:0] K_XOFF      = 8'h7C;  // K28.3
   localparam logic [7:0] K_LOS       = 8'hFF;  // K31.7, loss of signal
   localparam logic [7:0] K_ERROR     = 8'h00;  // K0.0, decode error
   localparam logic [7:0] D_56        = 8'hC5;  // D5.6 data byte

   // Lane word layout is {k_msb, k_lsb, high byte, low byte}
   localparam logic [17:0] IDLE_WORD  = {2'b10, K_COMMA, D_56};
   localparam logic [17:0] START_WORD = {2'b11, K_PKT_START, K_PKT_START};
   localparam logic [17:0] END_WORD   = {2'b11, K_PKT_END, K_PKT_END};
   localparam logic [17:0] XON_WORD   = {2'b11, K_XON, K_XON};
   localparam logic [17:0] XOFF_WORD  = {2'b11, K_XOFF, K_XOFF};
   localparam logic [17:0] LOS_WORD   = {2'b11, K_LOS, K_LOS};
   localparam logic [17:0] ERR_WORD   = {2'b11, K_ERROR, K_ERROR};

   // FIFO entry is {error, start, end, line[31:0]}
   localparam int ENTRY_W = 35;

   // CCITT CRC-16 start value
   localparam logic [15:0] CRC_INIT = 16'hFFFF;

   typedef enum logic [2:0] {
      ST_IDLE   = 3'd0,
      ST_FIRST1 = 3'd1,
      ST_FIRST2 = 3'd2,
      ST_PKT1   = 3'd3,
      ST_PKT2   = 3'd4,
      ST_CRC    = 3'd5,
      ST_ERROR  = 3'd6,
      ST_DONE   = 3'd7
   } framer_state_t;

endpackage

// ==== verilog/serdes_rx_top.sv ====
// ----------------------------------------------------------------------
// SERDES receive top level
// Aligner, framer, CRC check, packet FIFO and link monitor
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module serdes_rx_top
   import serdes_rx_pkg::*;
#(
   parameter int FIFO_AW = 5
)
(
   input  logic             ser_rx_clk,
   input  logic             rst_rxclk,
   input  logic [15:0]      ser_rx_data_i,
   input  logic             ser_rx_klsb_i,
   input  logic             ser_rx_kmsb_i,
   input  logic             out_ready_i,
   output logic [31:0]      out_data_o,
   output logic             out_sop_o,
   output logic             out_eop_o,
   output logic             out_err_o,
   output logic             out_valid_o,
   output logic [FIFO_AW:0] fifo_space_o,
   output logic [FIFO_AW:0] fifo_occupied_o,
   output logic             fifo_full_o,
   output logic             fifo_empty_o,
   output logic             link_up_o,
   output logic             xon_o,
   output logic             xoff_o
);

   logic [15:0]        lane_word;
   logic [1:0]         lane_k;
   logic               start_even;
   logic               start_odd;
   logic               odd_sel;
   logic               crc_clear;
   logic               crc_en;
   logic [15:0]        crc;
   logic               wr_en;
   logic [ENTRY_W-1:0] wr_data;
   logic               has_space;

   serdes_rx_align u_align (
      .ser_rx_clk   (ser_rx_clk),
      .rst_rxclk    (rst_rxclk),
      .rx_data_i    (ser_rx_data_i),
      .rx_klsb_i    (ser_rx_klsb_i),
      .rx_kmsb_i    (ser_rx_kmsb_i),
      .odd_sel_i    (odd_sel),
      .lane_word_o  (lane_word),
      .lane_k_o     (lane_k),
      .start_even_o (start_even),
      .start_odd_o  (start_odd)
   );

   serdes_rx_framer u_framer (
      .ser_rx_clk   (ser_rx_clk),
      .rst_rxclk    (rst_rxclk),
      .lane_word_i  (lane_word),
      .lane_k_i     (lane_k),
      .start_even_i (start_even),
      .start_odd_i  (start_odd),
      .crc_i        (crc),
      .has_space_i  (has_space),
      .odd_sel_o    (odd_sel),
      .crc_clear_o  (crc_clear),
      .crc_en_o     (crc_en),
      .wr_en_o      (wr_en),
      .wr_data_o    (wr_data)
   );

   serdes_rx_crc16 u_crc (
      .ser_rx_clk (ser_rx_clk),
      .rst_rxclk  (rst_rxclk),
      .clear_i    (crc_clear),
      .en_i       (crc_en),
      .data_i     (lane_word),
      .crc_o      (crc)
   );

   // Entry unpacks straight onto the output stream
   serdes_rx_fifo #(
      .FIFO_AW (FIFO_AW)
   ) u_fifo (
      .ser_rx_clk  (ser_rx_clk),
      .rst_rxclk   (rst_rxclk),
      .wr_en_i     (wr_en),
      .wr_data_i   (wr_data),
      .rd_ready_i  (out_ready_i),
      .has_space_o (has_space),
      .rd_valid_o  (out_valid_o),
      .rd_data_o   ({out_err_o, out_sop_o, out_eop_o, out_data_o}),
      .space_o     (fifo_space_o),
      .occupied_o  (fifo_occupied_o),
      .full_o      (fifo_full_o),
      .empty_o     (fifo_empty_o)
   );

   serdes_rx_link_mon u_link_mon (
      .ser_rx_clk (ser_rx_clk),
      .rst_rxclk  (rst_rxclk),
      .rx_data_i  (ser_rx_data_i),
      .rx_klsb_i  (ser_rx_klsb_i),
      .rx_kmsb_i  (ser_rx_kmsb_i),
      .link_up_o  (link_up_o),
      .xon_o      (xon_o),
      .xoff_o     (xoff_o)
   );

endmodule
